// File: hw/mem_stage_config.svh
`ifndef MEM_STAGE_CONFIG_SVH
`define MEM_STAGE_CONFIG_SVH

// Data and address width of the memory port
`define WORD_W 32

// Request credits granted by the data memory
// Any value from 1 to 4 fits the 3 bit counter
`define MEM_CREDITS 2

// Register file index width
`define REG_IDX_W 5

`endif

// File: hw/mem_stage_pkg.sv
package mem_stage_pkg;

    `include "mem_stage_config.svh"

    typedef logic [`WORD_W-1:0]    word_t;
    typedef logic [3:0]            byte_en_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [2:0]            credit_t;

    // Load/store width and signedness
    typedef enum logic [2:0] {
        MEM_BYTE   = 3'd0,
        MEM_BYTE_U = 3'd1,
        MEM_HALF   = 3'd2,
        MEM_HALF_U = 3'd3,
        MEM_WORD   = 3'd4
    } mem_type_e;

    // Register writeback source
    typedef enum logic [1:0] {
        WB_LOAD = 2'd0,
        WB_PC4  = 2'd1,
        WB_UIMM = 2'd2,
        WB_ALU  = 2'd3
    } wb_sel_e;

    typedef enum logic [1:0] {
        FENCE_IDLE     = 2'd0,
        FENCE_FLUSHING = 2'd1,
        FENCE_DONE     = 2'd2
    } fence_state_e;

endpackage

// File: hw/data_access_unit.sv
`timescale 1ns/100ps

`include "mem_stage_config.svh"

module data_access_unit (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   op_valid,
    input  logic                   op_load,
    input  logic                   op_store,
    input  mem_stage_pkg::mem_type_e op_type,
    input  mem_stage_pkg::word_t   op_addr,
    input  mem_stage_pkg::word_t   op_store_data,
    input  logic                   accept,
    input  logic                   mem_rvalid,
    input  mem_stage_pkg::word_t   mem_rdata,
    input  logic                   mem_credit_return,
    output logic                   mem_req,
    output logic                   mem_we,
    output mem_stage_pkg::word_t   mem_addr,
    output mem_stage_pkg::byte_en_t mem_byte_en,
    output mem_stage_pkg::word_t   mem_wdata,
    output logic                   access_done,
    output mem_stage_pkg::word_t   load_data,
    output logic                   misaligned
);

    logic [1:0]             byte_offset;
    logic                   bad_align;
    logic                   credit_avail;
    logic                   load_issued;
    logic                   load_req;
    logic                   store_req;
    mem_stage_pkg::credit_t credit_cnt;
    mem_stage_pkg::word_t   rdata_shifted;

    assign byte_offset = op_addr[1:0];

    // Halfwords need even addresses, words need word alignment
    always_comb begin
        case (op_type)
            mem_stage_pkg::MEM_HALF, mem_stage_pkg::MEM_HALF_U: bad_align = byte_offset[0];
            mem_stage_pkg::MEM_WORD: bad_align = (byte_offset != 2'b00);
            default: bad_align = 1'b0;
        endcase
    end

    assign misaligned = (op_load || op_store) && bad_align;

    always_comb begin
        case (op_type)
            mem_stage_pkg::MEM_BYTE, mem_stage_pkg::MEM_BYTE_U: begin
                mem_byte_en = 4'b0001 << byte_offset;
            end
            mem_stage_pkg::MEM_HALF, mem_stage_pkg::MEM_HALF_U: begin
                mem_byte_en = byte_offset[1] ? 4'b1100 : 4'b0011;
            end
            mem_stage_pkg::MEM_WORD: mem_byte_en = 4'b1111;
            default:                 mem_byte_en = 4'b0000;
        endcase
    end

    // Store data copied to every lane for the enables to pick from
    always_comb begin
        case (op_type)
            mem_stage_pkg::MEM_BYTE, mem_stage_pkg::MEM_BYTE_U: begin
                mem_wdata = {4{op_store_data[7:0]}};
            end
            mem_stage_pkg::MEM_HALF, mem_stage_pkg::MEM_HALF_U: begin
                mem_wdata = {2{op_store_data[15:0]}};
            end
            default: mem_wdata = op_store_data;
        endcase
    end

    assign credit_avail = (credit_cnt != '0);

    // One request per operation; a load waits for its data after issue
    assign store_req = op_valid && op_store && !bad_align && credit_avail;
    assign load_req  = op_valid && op_load && !bad_align && !load_issued && credit_avail;

    assign mem_req  = store_req || load_req;
    assign mem_we   = op_store;
    assign mem_addr = op_addr;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            credit_cnt <= mem_stage_pkg::credit_t'(`MEM_CREDITS);
        end else begin
            credit_cnt <= credit_cnt - mem_stage_pkg::credit_t'(mem_req)
                          + mem_stage_pkg::credit_t'(mem_credit_return);
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            load_issued <= 1'b0;
        end else if (accept) begin
            load_issued <= 1'b0;
        end else if (load_req) begin
            load_issued <= 1'b1;
        end
    end

    assign access_done = misaligned || store_req || (load_issued && mem_rvalid);

    // Bring the addressed lane down to bit 0
    assign rdata_shifted = mem_rdata >> {byte_offset, 3'b000};

    always_comb begin
        case (op_type)
            mem_stage_pkg::MEM_BYTE:   load_data = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
            mem_stage_pkg::MEM_BYTE_U: load_data = {24'd0, rdata_shifted[7:0]};
            mem_stage_pkg::MEM_HALF:   load_data = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
            mem_stage_pkg::MEM_HALF_U: load_data = {16'd0, rdata_shifted[15:0]};
            default:                   load_data = mem_rdata;
        endcase
    end

    // Returns never outrun requests
    a_credit_bound: assert property (@(posedge CLK) disable iff (!nRST)
        credit_cnt <= mem_stage_pkg::credit_t'(`MEM_CREDITS));

endmodule

// File: hw/fence_tracker.sv
`timescale 1ns/100ps

module fence_tracker (
    input  logic CLK,
    input  logic nRST,
    input  logic fence_valid,
    input  logic accept,
    input  logic iflush_done,
    input  logic dflush_done,
    output logic iflush_req,
    output logic dflush_req,
    output logic fence_done
);

    mem_stage_pkg::fence_state_e state;
    logic                        iflush_seen;
    logic                        dflush_seen;
    logic                        both_seen;

    // Done pulses may land in the same cycle or far apart
    assign both_seen = (iflush_seen || iflush_done) && (dflush_seen || dflush_done);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state       <= mem_stage_pkg::FENCE_IDLE;
            iflush_req  <= 1'b0;
            dflush_req  <= 1'b0;
            iflush_seen <= 1'b0;
            dflush_seen <= 1'b0;
        end else begin
            iflush_req <= 1'b0;
            dflush_req <= 1'b0;
            case (state)
                mem_stage_pkg::FENCE_IDLE: begin
                    if (fence_valid) begin
                        state       <= mem_stage_pkg::FENCE_FLUSHING;
                        iflush_req  <= 1'b1;
                        dflush_req  <= 1'b1;
                        iflush_seen <= 1'b0;
                        dflush_seen <= 1'b0;
                    end
                end
                mem_stage_pkg::FENCE_FLUSHING: begin
                    if (iflush_done) iflush_seen <= 1'b1;
                    if (dflush_done) dflush_seen <= 1'b1;
                    if (both_seen) state <= mem_stage_pkg::FENCE_DONE;
                end
                mem_stage_pkg::FENCE_DONE: begin
                    // Hold until writeback takes the fence
                    if (accept && fence_valid) state <= mem_stage_pkg::FENCE_IDLE;
                end
                default: state <= mem_stage_pkg::FENCE_IDLE;
            endcase
        end
    end

    assign fence_done = (state == mem_stage_pkg::FENCE_DONE);

    // Caches only answer a flush that is still pending
    a_done_only_while_flushing: assert property (@(posedge CLK) disable iff (!nRST)
        (iflush_done || dflush_done) |-> state == mem_stage_pkg::FENCE_FLUSHING);

endmodule

// File: hw/mem_writeback.sv
`timescale 1ns/100ps

module mem_writeback (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    op_valid,
    input  logic                    op_load,
    input  logic                    op_store,
    input  logic                    op_fence,
    input  logic                    op_reg_write,
    input  mem_stage_pkg::wb_sel_e  op_wb_sel,
    input  mem_stage_pkg::reg_idx_t op_rd,
    input  mem_stage_pkg::word_t    op_addr,
    input  mem_stage_pkg::word_t    op_pc4,
    input  mem_stage_pkg::word_t    op_imm_u,
    input  logic                    access_done,
    input  mem_stage_pkg::word_t    load_data,
    input  logic                    misaligned,
    input  logic                    fence_done,
    output logic                    op_ready,
    output logic                    accept,
    output logic                    wb_valid,
    output logic                    wb_reg_write,
    output mem_stage_pkg::reg_idx_t wb_rd,
    output mem_stage_pkg::word_t    wb_data,
    output logic                    exc_mal_load,
    output logic                    exc_mal_store,
    output mem_stage_pkg::word_t    exc_badaddr
);

    mem_stage_pkg::word_t wb_value;

    // Memory ops wait on the access unit, fences on the tracker
    always_comb begin
        if (op_load || op_store) begin
            op_ready = access_done;
        end else if (op_fence) begin
            op_ready = fence_done;
        end else begin
            op_ready = 1'b1;
        end
    end

    assign accept = op_valid && op_ready;

    always_comb begin
        case (op_wb_sel)
            mem_stage_pkg::WB_LOAD: wb_value = load_data;
            mem_stage_pkg::WB_PC4:  wb_value = op_pc4;
            mem_stage_pkg::WB_UIMM: wb_value = op_imm_u;
            default:                wb_value = op_addr;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wb_valid      <= 1'b0;
            wb_reg_write  <= 1'b0;
            exc_mal_load  <= 1'b0;
            exc_mal_store <= 1'b0;
        end else begin
            wb_valid      <= accept;
            // A faulting access never writes the register file
            wb_reg_write  <= accept && op_reg_write && !op_store && !misaligned;
            exc_mal_load  <= accept && op_load && misaligned;
            exc_mal_store <= accept && op_store && misaligned;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            wb_rd       <= op_rd;
            wb_data     <= wb_value;
            exc_badaddr <= op_addr;
        end
    end

endmodule

// File: hw/mem_stage_top.sv
`timescale 1ns/100ps

module mem_stage_top (
    input  logic                     CLK,
    input  logic                     nRST,
    // Execute stage
    input  logic                     op_valid,
    input  logic                     op_load,
    input  logic                     op_store,
    input  logic                     op_fence,
    input  mem_stage_pkg::mem_type_e op_type,
    input  mem_stage_pkg::wb_sel_e   op_wb_sel,
    input  mem_stage_pkg::reg_idx_t  op_rd,
    input  logic                     op_reg_write,
    input  mem_stage_pkg::word_t     op_addr,
    input  mem_stage_pkg::word_t     op_store_data,
    input  mem_stage_pkg::word_t     op_pc4,
    input  mem_stage_pkg::word_t     op_imm_u,
    output logic                     op_ready,
    // Data memory
    output logic                     mem_req,
    output logic                     mem_we,
    output mem_stage_pkg::word_t     mem_addr,
    output mem_stage_pkg::byte_en_t  mem_byte_en,
    output mem_stage_pkg::word_t     mem_wdata,
    input  logic                     mem_rvalid,
    input  mem_stage_pkg::word_t     mem_rdata,
    input  logic                     mem_credit_return,
    // Caches
    output logic                     iflush_req,
    output logic                     dflush_req,
    input  logic                     iflush_done,
    input  logic                     dflush_done,
    // Retire
    output logic                     wb_valid,
    output logic                     wb_reg_write,
    output mem_stage_pkg::reg_idx_t  wb_rd,
    output mem_stage_pkg::word_t     wb_data,
    output logic                     exc_mal_load,
    output logic                     exc_mal_store,
    output mem_stage_pkg::word_t     exc_badaddr
);

    logic                 accept;
    logic                 access_done;
    logic                 misaligned;
    logic                 fence_done;
    logic                 fence_valid;
    mem_stage_pkg::word_t load_data;

    assign fence_valid = op_valid && op_fence;

    data_access_unit dau_i (
        .CLK(CLK), .nRST(nRST),
        .op_valid(op_valid), .op_load(op_load), .op_store(op_store),
        .op_type(op_type), .op_addr(op_addr), .op_store_data(op_store_data),
        .accept(accept),
        .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata),
        .mem_credit_return(mem_credit_return),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_byte_en(mem_byte_en), .mem_wdata(mem_wdata),
        .access_done(access_done), .load_data(load_data), .misaligned(misaligned)
    );

    fence_tracker fence_i (
        .CLK(CLK), .nRST(nRST),
        .fence_valid(fence_valid), .accept(accept),
        .iflush_done(iflush_done), .dflush_done(dflush_done),
        .iflush_req(iflush_req), .dflush_req(dflush_req), .fence_done(fence_done)
    );

    mem_writeback wb_i (
        .CLK(CLK), .nRST(nRST),
        .op_valid(op_valid), .op_load(op_load), .op_store(op_store),
        .op_fence(op_fence), .op_reg_write(op_reg_write), .op_wb_sel(op_wb_sel),
        .op_rd(op_rd), .op_addr(op_addr), .op_pc4(op_pc4), .op_imm_u(op_imm_u),
        .access_done(access_done), .load_data(load_data),
        .misaligned(misaligned), .fence_done(fence_done),
        .op_ready(op_ready), .accept(accept),
        .wb_valid(wb_valid), .wb_reg_write(wb_reg_write), .wb_rd(wb_rd),
        .wb_data(wb_data), .exc_mal_load(exc_mal_load),
        .exc_mal_store(exc_mal_store), .exc_badaddr(exc_badaddr)
    );

endmodule

// File: sim/data_mem_model.sv
`timescale 1ns/100ps

module data_mem_model (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        req,
    input  logic        we,
    input  logic [31:0] addr,
    input  logic [3:0]  byte_en,
    input  logic [31:0] wdata,
    output logic        rvalid,
    output logic [31:0] rdata,
    output logic        credit_return
);

    logic [7:0]  mem [0:255];
    integer      seed = 32'ha22bc620;
    int unsigned cycle;
    int unsigned last_due;
    int unsigned due;
    int unsigned due_q[$];
    logic        load_q[$];
    logic [31:0] data_q[$];

    // Fill pattern uses the full byte address
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i * 37 + 11);
        end
    end

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rvalid        <= 1'b0;
            rdata         <= '0;
            credit_return <= 1'b0;
            cycle         = 0;
            last_due      = 0;
            due_q.delete();
            load_q.delete();
            data_q.delete();
        end else begin
            cycle = cycle + 1;
            rvalid        <= 1'b0;
            credit_return <= 1'b0;
            // At most one response per cycle, in request order
            if (due_q.size() > 0 && due_q[0] == cycle) begin
                void'(due_q.pop_front());
                rvalid        <= load_q.pop_front();
                rdata         <= data_q.pop_front();
                credit_return <= 1'b1;
            end
            if (req) begin
                if (we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (byte_en[b]) mem[{addr[7:2], 2'(b)}] = wdata[8*b +: 8];
                    end
                end
                due = cycle + 1 + ($unsigned($random(seed)) % 4);
                if (due <= last_due) due = last_due + 1;
                last_due = due;
                due_q.push_back(due);
                load_q.push_back(!we);
                data_q.push_back({mem[{addr[7:2], 2'd3}], mem[{addr[7:2], 2'd2}],
                                  mem[{addr[7:2], 2'd1}], mem[{addr[7:2], 2'd0}]});
            end
        end
    end

endmodule

// File: sim/mem_stage_tb.sv
`timescale 1ns/100ps

`include "mem_stage_config.svh"

module mem_stage_tb;

    logic CLK = 1'b0;
    logic nRST;
    logic op_valid, op_load, op_store, op_fence, op_reg_write, op_ready;
    mem_stage_pkg::mem_type_e op_type;
    mem_stage_pkg::wb_sel_e   op_wb_sel;
    logic [4:0]  op_rd, wb_rd;
    logic [31:0] op_addr, op_store_data, op_pc4, op_imm_u;
    logic        mem_req, mem_we, mem_rvalid, mem_credit_return;
    logic [3:0]  mem_byte_en;
    logic [31:0] mem_addr, mem_wdata, mem_rdata;
    logic        iflush_req, dflush_req, iflush_done, dflush_done;
    logic        wb_valid, wb_reg_write, exc_mal_load, exc_mal_store;
    logic [31:0] wb_data, exc_badaddr;

    integer      seed = 32'ha22bc620;
    int          cyc = 0;
    int          ops_issued = 0;
    int          credits = `MEM_CREDITS;
    int          fences = 0;
    int          iflush_cnt = 0;
    int          dflush_cnt = 0;
    logic        iflush_seen = 1'b0;
    logic        dflush_seen = 1'b0;
    logic        no_req = 1'b0;
    logic [7:0]  shadow [0:255];
    logic [31:0] a;

    // Expected retire records
    logic        q_rw[$], q_mall[$], q_mals[$];
    logic [4:0]  q_rd[$];
    logic [31:0] q_data[$], q_bad[$];
    int          q_cyc[$];

    mem_stage_top dut_i (.*);

    data_mem_model mem_i (
        .CLK(CLK), .nRST(nRST), .req(mem_req), .we(mem_we), .addr(mem_addr),
        .byte_en(mem_byte_en), .wdata(mem_wdata), .rvalid(mem_rvalid),
        .rdata(mem_rdata), .credit_return(mem_credit_return)
    );

    always #50 CLK = ~CLK;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    function automatic logic is_misaligned(input mem_stage_pkg::mem_type_e t,
                                           input logic [31:0] addr);
        if (t == mem_stage_pkg::MEM_HALF || t == mem_stage_pkg::MEM_HALF_U) return addr[0];
        if (t == mem_stage_pkg::MEM_WORD) return addr[1:0] != 2'b00;
        return 1'b0;
    endfunction

    // Reference writeback value with loads taken from the shadow memory
    function automatic logic [31:0] expected_data(input mem_stage_pkg::mem_type_e t,
                                                  input mem_stage_pkg::wb_sel_e sel,
                                                  input logic [31:0] addr,
                                                  input logic [31:0] pc4,
                                                  input logic [31:0] immu);
        logic [7:0]  b0;
        logic [15:0] h;
        b0 = shadow[addr[7:0]];
        h  = {shadow[addr[7:0] + 8'd1], b0};
        case (sel)
            mem_stage_pkg::WB_PC4:  return pc4;
            mem_stage_pkg::WB_UIMM: return immu;
            mem_stage_pkg::WB_ALU:  return addr;
            default: begin
                case (t)
                    mem_stage_pkg::MEM_BYTE:   return {{24{b0[7]}}, b0};
                    mem_stage_pkg::MEM_BYTE_U: return {24'd0, b0};
                    mem_stage_pkg::MEM_HALF:   return {{16{h[15]}}, h};
                    mem_stage_pkg::MEM_HALF_U: return {16'd0, h};
                    default: return {shadow[addr[7:0] + 8'd3], shadow[addr[7:0] + 8'd2], h};
                endcase
            end
        endcase
    endfunction

    task automatic apply_store(input mem_stage_pkg::mem_type_e t, input logic [31:0] addr,
                               input logic [31:0] data);
        int n;
        n = (t == mem_stage_pkg::MEM_WORD) ? 4 : (t >= mem_stage_pkg::MEM_HALF) ? 2 : 1;
        for (int i = 0; i < n; i++) begin
            shadow[addr[7:0] + 8'(i)] = data[8*i +: 8];
        end
    endtask

    // Called 10 ns after a rising edge; returns at the same point of a later cycle
    task automatic run_op(input logic ld, input logic st, input logic fn,
                          input mem_stage_pkg::mem_type_e t, input mem_stage_pkg::wb_sel_e sel,
                          input logic [31:0] addr, input logic [31:0] sdata);
        logic mis;
        ops_issued++;
        op_load       = ld;
        op_store      = st;
        op_fence      = fn;
        op_type       = t;
        op_wb_sel     = sel;
        op_rd         = 5'(ops_issued);
        op_reg_write  = !fn;
        op_addr       = addr;
        op_store_data = sdata;
        op_pc4        = addr ^ 32'h1000_0004;
        op_imm_u      = {addr[19:0], 12'h000};
        if (fn) begin
            iflush_seen = 1'b0;
            dflush_seen = 1'b0;
        end
        op_valid = 1'b1;
        do @(negedge CLK); while (!op_ready);
        mis = (ld || st) && is_misaligned(t, addr);
        if (fn) begin
            check("iflush_done seen", iflush_seen, 1'b1);
            check("dflush_done seen", dflush_seen, 1'b1);
            check("iflush_req count", iflush_cnt, fences + 1);
            check("dflush_req count", dflush_cnt, fences + 1);
            fences++;
        end
        q_rw.push_back(!fn && !st && !mis);
        q_rd.push_back(op_rd);
        q_data.push_back(expected_data(t, sel, addr, op_pc4, op_imm_u));
        q_mall.push_back(ld && mis);
        q_mals.push_back(st && mis);
        q_bad.push_back(addr);
        q_cyc.push_back(cyc + 1);
        if (st && !mis) apply_store(t, addr, sdata);
        @(posedge CLK);
        #10;
        op_valid = 1'b0;
        no_req   = 1'b0;
    endtask

    // Compare process
    always @(negedge CLK) begin
        if (nRST && wb_valid) begin
            if (q_rd.size() == 0) fail_run("wb_valid seen with no accepted operation pending");
            check("retire cycle", cyc, q_cyc.pop_front());
            check("wb_rd", wb_rd, q_rd.pop_front());
            check("wb_reg_write", wb_reg_write, q_rw[0]);
            if (q_rw[0]) check("wb_data", wb_data, q_data[0]);
            void'(q_rw.pop_front());
            void'(q_data.pop_front());
            check("exc_mal_load", exc_mal_load, q_mall[0]);
            check("exc_mal_store", exc_mal_store, q_mals[0]);
            if (q_mall[0] || q_mals[0]) check("exc_badaddr", exc_badaddr, q_bad[0]);
            void'(q_mall.pop_front());
            void'(q_mals.pop_front());
            void'(q_bad.pop_front());
        end
    end

    // Credit and request monitor
    always @(negedge CLK) begin
        if (nRST) begin
            if (mem_req && credits == 0) fail_run("mem_req driven with no credit left");
            if (mem_req && no_req) fail_run("mem_req driven for a misaligned access");
            credits = credits - int'(mem_req) + int'(mem_credit_return);
            if (credits > `MEM_CREDITS) fail_run("more credits returned than granted");
            if (iflush_done) iflush_seen = 1'b1;
            if (dflush_done) dflush_seen = 1'b1;
        end
    end

    // Cache responders with random done delays
    always begin
        @(negedge CLK);
        if (nRST && iflush_req) begin
            iflush_cnt++;
            repeat (1 + ($unsigned($random(seed)) % 6)) @(posedge CLK);
            #10 iflush_done = 1'b1;
            @(posedge CLK);
            #10 iflush_done = 1'b0;
        end
    end

    always begin
        @(negedge CLK);
        if (nRST && dflush_req) begin
            dflush_cnt++;
            repeat (1 + ($unsigned($random(seed)) % 6)) @(posedge CLK);
            #10 dflush_done = 1'b1;
            @(posedge CLK);
            #10 dflush_done = 1'b0;
        end
    end

    always @(posedge CLK) begin
        cyc++;
        if (cyc > 40 * ops_issued + 20) fail_run("Timeout: an operation was never retired");
    end

    initial begin
        for (int i = 0; i < 256; i++) shadow[i] = 8'(i * 37 + 11);
        nRST = 1'b0;
        op_valid = 1'b0;
        op_load = 1'b0;
        op_store = 1'b0;
        op_fence = 1'b0;
        op_reg_write = 1'b0;
        op_type = mem_stage_pkg::MEM_WORD;
        op_wb_sel = mem_stage_pkg::WB_ALU;
        op_rd = '0;
        op_addr = '0;
        op_store_data = '0;
        op_pc4 = '0;
        op_imm_u = '0;
        iflush_done = 1'b0;
        dflush_done = 1'b0;
        repeat (5) @(posedge CLK);
        #10 nRST = 1'b1;
        @(negedge CLK);
        check("mem_req after reset", mem_req, 1'b0);
        check("iflush_req after reset", iflush_req, 1'b0);
        check("dflush_req after reset", dflush_req, 1'b0);
        check("wb_valid after reset", wb_valid, 1'b0);
        check("exc_mal_load after reset", exc_mal_load, 1'b0);
        check("exc_mal_store after reset", exc_mal_store, 1'b0);
        @(posedge CLK);
        #10;
        // Stores of each width, then loads of every type from the same word
        // Byte stores walk all four lanes, halfword stores both halves
        for (int n = 0; n < 12; n++) begin
            a = $random(seed) & 32'hfc;
            run_op(0, 1, 0, mem_stage_pkg::mem_type_e'(2 * (n % 3)), mem_stage_pkg::WB_ALU,
                   a | 32'((n % 3 == 0) ? n / 3 : (n % 3 == 1) ? 2 * ((n / 3) % 2) : 0),
                   $random(seed));
            for (int t = 0; t < 5; t++) begin
                run_op(1, 0, 0, mem_stage_pkg::mem_type_e'(t), mem_stage_pkg::WB_LOAD,
                       a | ((t < 2) ? ($random(seed) & 3) : (t < 4) ? ($random(seed) & 2) : 0),
                       '0);
            end
        end
        run_op(0, 0, 0, mem_stage_pkg::MEM_WORD, mem_stage_pkg::WB_ALU, 32'h1234_5678, '0);
        run_op(0, 0, 0, mem_stage_pkg::MEM_WORD, mem_stage_pkg::WB_PC4, 32'h0000_4000, '0);
        run_op(0, 0, 0, mem_stage_pkg::MEM_WORD, mem_stage_pkg::WB_UIMM, 32'h000a_bcde, '0);
        no_req = 1'b1;
        run_op(1, 0, 0, mem_stage_pkg::MEM_HALF, mem_stage_pkg::WB_LOAD, 32'h41, '0);
        no_req = 1'b1;
        run_op(1, 0, 0, mem_stage_pkg::MEM_WORD, mem_stage_pkg::WB_LOAD, 32'h52, '0);
        no_req = 1'b1;
        run_op(0, 1, 0, mem_stage_pkg::MEM_HALF_U, mem_stage_pkg::WB_ALU, 32'h63, '1);
        no_req = 1'b1;
        run_op(0, 1, 0, mem_stage_pkg::MEM_WORD, mem_stage_pkg::WB_ALU, 32'h77, '1);
        // Back-to-back store burst
        for (int n = 0; n < 8; n++) begin
            run_op(0, 1, 0, mem_stage_pkg::MEM_WORD, mem_stage_pkg::WB_ALU,
                   32'h80 + 32'(4 * n), $random(seed));
        end
        for (int n = 0; n < 4; n++) begin
            run_op(0, 0, 1, mem_stage_pkg::MEM_WORD, mem_stage_pkg::WB_ALU, '0, '0);
        end
        repeat (4) @(posedge CLK);
        check("iflush_req total", iflush_cnt, fences);
        check("dflush_req total", dflush_cnt, fences);
        if (q_rd.size() != 0) begin
            fail_run("Accepted operations never retired");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// File: project.f
+incdir+hw
hw/mem_stage_pkg.sv
hw/data_access_unit.sv
hw/fence_tracker.sv
hw/mem_writeback.sv
hw/mem_stage_top.sv
sim/data_mem_model.sv
sim/mem_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory stage testbench with Verilator

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module mem_stage_tb -o mem_stage_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/mem_stage_sim > sim.log 2>&1 ; cat sim.log

grep -q "Testbench passed" sim.log && echo "Simulation PASS" \
    || { echo "Simulation FAIL"; exit 1; }
